/* design/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

    // Link widths
    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int strb_w  = data_w / 8;
    localparam int resp_w  = 2;
    localparam int id_w    = 4;                     // AXI id, always driven 0
    localparam int len_w   = 8;                     // AXI4 burst length field
    localparam int timer_w = 64;                    // mtime / mtimecmp

    // Address map
    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
    localparam logic [addr_w-1:0] clint_mask = 32'hFFFF_0000;

    // CLINT register offsets inside the window
    localparam logic [addr_w-1:0] clint_msip_off        = 32'h0000_0000;
    localparam logic [addr_w-1:0] clint_mtimecmp_off    = 32'h0000_4000;
    localparam logic [addr_w-1:0] clint_mtimecmp_hi_off = 32'h0000_4004;
    localparam logic [addr_w-1:0] clint_mtime_off       = 32'h0000_BFF8;
    localparam logic [addr_w-1:0] clint_mtime_hi_off    = 32'h0000_BFFC;

    // Fixed AXI field values
    localparam logic [2:0]        axi_size_word   = 3'b010;  // 4 bytes per beat
    localparam logic [1:0]        axi_burst_incr  = 2'b01;
    localparam logic [resp_w-1:0] axi_resp_okay   = 2'd0;
    localparam logic [resp_w-1:0] axi_resp_slverr = 2'd2;

    // Single-beat request on core port and internal links
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } bus_req_t;

    // Single-cycle response pulse, no ready
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] rdata;
        logic [resp_w-1:0] resp;
    } bus_rsp_t;

    // Read-only fetch request
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } fetch_req_t;

    // AR and AW share one layout
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
        logic [len_w-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ax_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic              valid;
        logic [resp_w-1:0] resp;
        logic [id_w-1:0]   id;
    } axi_b_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        logic [resp_w-1:0] resp;
        logic              last;
        logic [id_w-1:0]   id;
    } axi_r_t;

    // Arbiter FSM
    typedef enum logic [1:0] {
        arb_idle    = 2'd0,   // Choosing a requester
        arb_busy    = 2'd1,   // Waiting on the router
        arb_respond = 2'd2    // Response pulse to owner
    } arb_state_e;

endpackage

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import fabric_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    // Fetch port, read only
    input  fetch_req_t fetch_req,
    output logic       fetch_ready,
    output bus_rsp_t   fetch_rsp,
    // Load/store port
    input  bus_req_t   lsu_req,
    output logic       lsu_ready,
    output bus_rsp_t   lsu_rsp,
    // Granted path toward the router
    output bus_req_t   grant_req,
    input  logic       grant_ready,
    input  bus_rsp_t   grant_rsp
);

    arb_state_e state_q;
    logic       prio_lsu_q;    // Set when load/store goes first next time
    logic       owner_lsu_q;   // Owner of the transaction in flight
    bus_rsp_t   rsp_q;         // Captured router response
    logic       pick_lsu;
    logic       in_idle;
    logic       accept;

    assign in_idle = (state_q == arb_idle);

    // Round robin, load/store wins on its turn or when fetch is quiet
    assign pick_lsu = lsu_req.valid && (!fetch_req.valid || prio_lsu_q);

    always_comb begin
        grant_req = '0;
        if (in_idle) begin
            if (pick_lsu) begin
                grant_req = lsu_req;
            end else begin
                grant_req.valid = fetch_req.valid;   // Fetch widened to a read
                grant_req.write = 1'b0;
                grant_req.addr  = fetch_req.addr;
            end
        end
    end

    assign accept      = in_idle && grant_req.valid && grant_ready;
    assign lsu_ready   = in_idle && pick_lsu && grant_ready;
    assign fetch_ready = in_idle && fetch_req.valid && !pick_lsu && grant_ready;

    // Response goes to the owner only
    always_comb begin
        fetch_rsp       = rsp_q;
        lsu_rsp         = rsp_q;
        fetch_rsp.valid = (state_q == arb_respond) && !owner_lsu_q;
        lsu_rsp.valid   = (state_q == arb_respond) && owner_lsu_q;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= arb_idle;
            prio_lsu_q  <= 1'b0;
            owner_lsu_q <= 1'b0;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (accept) begin
                        owner_lsu_q <= pick_lsu;     // Remember who asked
                        state_q     <= arb_busy;
                    end
                end
                arb_busy: begin
                    if (grant_rsp.valid) begin
                        state_q <= arb_respond;
                    end
                end
                arb_respond: begin
                    prio_lsu_q <= !owner_lsu_q;      // Other side goes first next
                    state_q    <= arb_idle;
                end
                default: begin
                    state_q <= arb_idle;
                end
            endcase
        end
    end

    // Response payload
    always_ff @(posedge clock) begin
        if (state_q == arb_busy && grant_rsp.valid) begin
            rsp_q <= grant_rsp;
        end
    end

endmodule

`default_nettype wire

/* design/clint_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module clint_timer import fabric_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  bus_req_t clint_req,
    output bus_rsp_t clint_rsp,
    output logic     timer_irq,
    output logic     soft_irq
);

    logic [timer_w-1:0] mtime_q;
    logic [timer_w-1:0] mtimecmp_q;
    logic               msip_q;
    logic               rsp_valid_q;
    logic [data_w-1:0]  rsp_data_q;
    logic [resp_w-1:0]  rsp_resp_q;
    logic [addr_w-1:0]  off;          // Offset inside the window
    logic [data_w-1:0]  rd_data;
    logic               rd_err;
    logic               wr_en;

    // Byte-lane merge under strobes
    function automatic logic [data_w-1:0] merge_bytes(
        input logic [data_w-1:0] old_v,
        input logic [data_w-1:0] new_v,
        input logic [strb_w-1:0] strb
    );
        logic [data_w-1:0] res;
        res = old_v;
        for (int i = 0; i < strb_w; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign off   = clint_req.addr & ~clint_mask;
    assign wr_en = clint_req.valid && clint_req.write;

    // Register read mux
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (off)
            clint_msip_off:        rd_data = {{(data_w-1){1'b0}}, msip_q};
            clint_mtimecmp_off:    rd_data = mtimecmp_q[31:0];
            clint_mtimecmp_hi_off: rd_data = mtimecmp_q[63:32];
            clint_mtime_off:       rd_data = mtime_q[31:0];
            clint_mtime_hi_off:    rd_data = mtime_q[63:32];
            default:               rd_err  = 1'b1;   // Hole in the map
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;           // No timer interrupt out of reset
            msip_q      <= 1'b0;
            timer_irq   <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 1'b1;                // Free running
            timer_irq   <= (mtime_q >= mtimecmp_q);
            rsp_valid_q <= clint_req.valid;               // Answer next cycle
            if (wr_en) begin
                case (off)
                    clint_msip_off: begin
                        if (clint_req.wstrb[0]) begin
                            msip_q <= clint_req.wdata[0];
                        end
                    end
                    clint_mtimecmp_off: begin
                        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0],
                                                        clint_req.wdata,
                                                        clint_req.wstrb);
                    end
                    clint_mtimecmp_hi_off: begin
                        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32],
                                                         clint_req.wdata,
                                                         clint_req.wstrb);
                    end
                    default: begin
                        // mtime is read only here
                    end
                endcase
            end
        end
    end

    // Response payload
    always_ff @(posedge clock) begin
        if (clint_req.valid) begin
            rsp_data_q <= (clint_req.write || rd_err) ? '0 : rd_data;
            rsp_resp_q <= rd_err ? axi_resp_slverr : axi_resp_okay;
        end
    end

    assign clint_rsp = '{valid: rsp_valid_q, rdata: rsp_data_q, resp: rsp_resp_q};
    assign soft_irq  = msip_q;

endmodule

`default_nettype wire

/* design/bus_router.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_router import fabric_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    // From the arbiter
    input  bus_req_t grant_req,
    output logic     grant_ready,
    output bus_rsp_t grant_rsp,
    // CLINT link
    output bus_req_t clint_req,
    input  bus_rsp_t clint_rsp,
    // External AXI master
    output axi_ax_t  ar,
    input  logic     arready,
    output axi_ax_t  aw,
    input  logic     awready,
    output axi_w_t   w,
    input  logic     wready,
    input  axi_r_t   r,
    output logic     rready,
    input  axi_b_t   b,
    output logic     bready
);

    typedef enum logic [1:0] {
        rt_idle  = 2'd0,
        rt_clint = 2'd1,
        rt_read  = 2'd2,
        rt_write = 2'd3
    } rt_state_e;

    rt_state_e state_q;
    bus_req_t  req_q;          // Granted request payload
    logic      clint_vld_q;    // One-cycle CLINT strobe
    logic      ar_pend_q;
    logic      aw_pend_q;
    logic      w_pend_q;
    logic      hit_clint;

    assign grant_ready = (state_q == rt_idle);
    assign hit_clint   = (grant_req.addr & clint_mask) == clint_base;

    always_comb begin
        clint_req       = req_q;
        clint_req.valid = clint_vld_q;
    end

    // Fixed single-beat fields
    assign ar = '{valid: ar_pend_q, addr: req_q.addr, id: '0, len: '0,
                  size: axi_size_word, burst: axi_burst_incr};
    assign aw = '{valid: aw_pend_q, addr: req_q.addr, id: '0, len: '0,
                  size: axi_size_word, burst: axi_burst_incr};
    assign w  = '{valid: w_pend_q, data: req_q.wdata, strb: req_q.wstrb, last: 1'b1};

    assign rready = (state_q == rt_read) && !ar_pend_q;               // After AR done
    assign bready = (state_q == rt_write) && !aw_pend_q && !w_pend_q; // After AW and W

    // Response back to the arbiter
    always_comb begin
        grant_rsp = '0;
        case (state_q)
            rt_clint: begin
                grant_rsp = clint_rsp;
            end
            rt_read: begin
                grant_rsp.valid = r.valid && rready;
                grant_rsp.rdata = r.data;
                // Unexpected beat shape flagged as slave error
                grant_rsp.resp  = (r.last && r.id == '0) ? r.resp : axi_resp_slverr;
            end
            rt_write: begin
                grant_rsp.valid = b.valid && bready;
                grant_rsp.resp  = (b.id == '0) ? b.resp : axi_resp_slverr;
            end
            default: begin
                grant_rsp = '0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= rt_idle;
            clint_vld_q <= 1'b0;
            ar_pend_q   <= 1'b0;
            aw_pend_q   <= 1'b0;
            w_pend_q    <= 1'b0;
        end else begin
            clint_vld_q <= 1'b0;
            case (state_q)
                rt_idle: begin
                    if (grant_req.valid) begin
                        if (hit_clint) begin
                            clint_vld_q <= 1'b1;
                            state_q     <= rt_clint;
                        end else if (grant_req.write) begin
                            aw_pend_q <= 1'b1;       // AW and W raised together
                            w_pend_q  <= 1'b1;
                            state_q   <= rt_write;
                        end else begin
                            ar_pend_q <= 1'b1;
                            state_q   <= rt_read;
                        end
                    end
                end
                rt_clint: begin
                    if (clint_rsp.valid) begin
                        state_q <= rt_idle;
                    end
                end
                rt_read: begin
                    if (ar_pend_q && arready) begin
                        ar_pend_q <= 1'b0;
                    end
                    if (grant_rsp.valid) begin
                        state_q <= rt_idle;
                    end
                end
                rt_write: begin
                    if (aw_pend_q && awready) begin
                        aw_pend_q <= 1'b0;
                    end
                    if (w_pend_q && wready) begin
                        w_pend_q <= 1'b0;
                    end
                    if (grant_rsp.valid) begin
                        state_q <= rt_idle;
                    end
                end
                default: begin
                    state_q <= rt_idle;
                end
            endcase
        end
    end

    // Latch payload at acceptance
    always_ff @(posedge clock) begin
        if (grant_req.valid && grant_ready) begin
            req_q <= grant_req;
        end
    end

endmodule

`default_nettype wire

/* design/cpu_fabric_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_fabric_top import fabric_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    // Core fetch port
    input  fetch_req_t fetch_req,
    output logic       fetch_ready,
    output bus_rsp_t   fetch_rsp,
    // Core load/store port
    input  bus_req_t   lsu_req,
    output logic       lsu_ready,
    output bus_rsp_t   lsu_rsp,
    // External AXI master
    output axi_ax_t    io_master_ar,
    input  logic       io_master_arready,
    output axi_ax_t    io_master_aw,
    input  logic       io_master_awready,
    output axi_w_t     io_master_w,
    input  logic       io_master_wready,
    input  axi_r_t     io_master_r,
    output logic       io_master_rready,
    input  axi_b_t     io_master_b,
    output logic       io_master_bready,
    // Interrupts toward the core
    output logic       timer_irq,
    output logic       soft_irq
);

    bus_req_t grant_req;    // Arbiter to router
    logic     grant_ready;
    bus_rsp_t grant_rsp;
    bus_req_t clint_req;    // Router to CLINT
    bus_rsp_t clint_rsp;

    bus_arbiter u_arbiter (
        .clock       (clock),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .fetch_rsp   (fetch_rsp),
        .lsu_req     (lsu_req),
        .lsu_ready   (lsu_ready),
        .lsu_rsp     (lsu_rsp),
        .grant_req   (grant_req),
        .grant_ready (grant_ready),
        .grant_rsp   (grant_rsp)
    );

    bus_router u_router (
        .clock       (clock),
        .arst_n      (arst_n),
        .grant_req   (grant_req),
        .grant_ready (grant_ready),
        .grant_rsp   (grant_rsp),
        .clint_req   (clint_req),
        .clint_rsp   (clint_rsp),
        .ar          (io_master_ar),
        .arready     (io_master_arready),
        .aw          (io_master_aw),
        .awready     (io_master_awready),
        .w           (io_master_w),
        .wready      (io_master_wready),
        .r           (io_master_r),
        .rready      (io_master_rready),
        .b           (io_master_b),
        .bready      (io_master_bready)
    );

    clint_timer u_clint (
        .clock     (clock),
        .arst_n    (arst_n),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule

`default_nettype wire

/* sim/tb_cpu_fabric.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_fabric import fabric_pkg::*; ();

    // One table row per transaction
    typedef struct packed {
        logic              use_lsu;   // 0 fetch, 1 load/store
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] exp_data;
        logic [resp_w-1:0] exp_resp;
    } vec_t;

    localparam int          num_vec  = 13;
    localparam int          wait_max = 200;            // Cycles per wait loop
    localparam logic [31:0] ext_base = 32'h8000_0000;  // External memory window

    logic       clock = 1'b0;
    logic       arst_n;
    fetch_req_t fetch_req;
    logic       fetch_ready;
    bus_rsp_t   fetch_rsp;
    bus_req_t   lsu_req;
    logic       lsu_ready;
    bus_rsp_t   lsu_rsp;
    axi_ax_t    io_master_ar;
    logic       io_master_arready;
    axi_ax_t    io_master_aw;
    logic       io_master_awready;
    axi_w_t     io_master_w;
    logic       io_master_wready;
    axi_r_t     io_master_r;
    logic       io_master_rready;
    axi_b_t     io_master_b;
    logic       io_master_bready;
    logic       timer_irq;
    logic       soft_irq;

    vec_t              vec_tab [num_vec];
    logic [data_w-1:0] mem [0:255];           // External slave storage
    logic [1:0]        delay_tab [0:63];      // Slave ready/response delays
    int                dly_idx = 0;
    logic              grant_log [$];         // 0 fetch, 1 lsu, in grant order
    logic [addr_w-1:0] ax_addr_q [$];         // Issued external addresses
    axi_w_t            w_exp_q [$];           // Expected W beats in issue order
    logic [1:0]        ar_wait, aw_wait, w_wait, r_wait, b_wait;
    logic              r_pend, b_pend, aw_got, w_got;
    logic [7:0]        rd_idx, wr_idx;
    logic [data_w-1:0] w_data;
    logic [strb_w-1:0] w_strb;
    int                bi;
    bus_rsp_t          rsp;
    int                lat;
    logic [data_w-1:0] t_now;

    cpu_fabric_top dut (.*);

    always #4 clock = ~clock;                 // 8 ns period

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error t=%0t %s: got v=%b d=%h r=%0d expected v=%b d=%h r=%0d",
                     $time, name, got.valid, got.rdata, got.resp, exp.valid, exp.rdata, exp.resp));
        end
    endtask

    task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error t=%0t %s: got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error t=%0t %s: got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_irq(input logic exp_timer, input logic exp_soft);
        if (timer_irq !== exp_timer) begin
            fail_now($sformatf("Error t=%0t timer_irq: got %b expected %b",
                     $time, timer_irq, exp_timer));
        end
        if (soft_irq !== exp_soft) begin
            fail_now($sformatf("Error t=%0t soft_irq: got %b expected %b",
                     $time, soft_irq, exp_soft));
        end
    endtask

    function automatic logic in_clint(input logic [addr_w-1:0] a);
        return (a & clint_mask) == clint_base;
    endfunction

    function automatic logic [1:0] next_delay();
        logic [1:0] d;
        d = delay_tab[dly_idx % 64];
        dly_idx++;
        return d;
    endfunction

    // AR/AW fields against the address issued at grant
    task automatic check_ax_issue(input string name, input axi_ax_t got);
        axi_ax_t exp;
        if (ax_addr_q.size() == 0) begin
            fail_now($sformatf("%s handshake seen with no external request issued", name));
        end
        exp = '{valid: 1'b1, addr: ax_addr_q.pop_front(), id: '0, len: '0,
                size: axi_size_word, burst: axi_burst_incr};
        check_ax(name, got, exp);
    endtask

    // W beat against the write data issued at grant
    task automatic check_w_issue(input axi_w_t got);
        axi_w_t exp;
        if (w_exp_q.size() == 0) begin
            fail_now("W handshake seen with no external write issued");
        end
        exp = w_exp_q.pop_front();
        check_w("io_master_w", got, exp);
    endtask

    // One request on one port, returns response and cycles after acceptance
    // Request goes out on the calling edge so a port can re-request without a gap
    task automatic do_access(input logic use_lsu, input logic wr, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] data, input logic [strb_w-1:0] strb,
                             output bus_rsp_t got, output int cycles);
        int   cnt;
        logic seen;
        cnt    = 0;
        seen   = 1'b0;
        cycles = 0;
        got    = '0;
        if (use_lsu) begin
            lsu_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: data, wstrb: strb};
        end else begin
            fetch_req <= '{valid: 1'b1, addr: addr};
        end
        while (!seen) begin                    // Acceptance edge
            @(posedge clock);
            seen = use_lsu ? lsu_ready : fetch_ready;
            cnt++;
            if (cnt > wait_max) begin
                fail_now($sformatf("Request to %h was never accepted", addr));
            end
        end
        if (use_lsu) begin
            lsu_req <= '0;
        end else begin
            fetch_req <= '0;
        end
        seen = 1'b0;
        while (!seen) begin                    // Response pulse
            @(posedge clock);
            got = use_lsu ? lsu_rsp : fetch_rsp;
            seen = got.valid;
            cycles++;
            if (cycles > wait_max) begin
                fail_now($sformatf("No response for request to %h", addr));
            end
        end
    endtask

    // Two back-to-back reads on one port
    task automatic run_port(input logic use_lsu, input logic [addr_w-1:0] a0,
                            input logic [addr_w-1:0] a1);
        bus_rsp_t got;
        int       cycles;
        do_access(use_lsu, 1'b0, a0, '0, '0, got, cycles);
        check_rsp(use_lsu ? "lsu_rsp" : "fetch_rsp", got,
                  '{valid: 1'b1, rdata: a0, resp: axi_resp_okay});
        do_access(use_lsu, 1'b0, a1, '0, '0, got, cycles);
        check_rsp(use_lsu ? "lsu_rsp" : "fetch_rsp", got,
                  '{valid: 1'b1, rdata: a1, resp: axi_resp_okay});
    endtask

    task automatic wait_timer(input logic exp);
        int cnt;
        cnt = 0;
        while (timer_irq !== exp) begin
            @(posedge clock);
            cnt++;
            if (cnt > wait_max) begin
                fail_now($sformatf("timer_irq did not reach %b in time", exp));
            end
        end
    endtask

    // Grant monitor and external AXI slave
    always @(posedge clock) begin
        if (arst_n) begin
            if (fetch_req.valid && fetch_ready) begin
                grant_log.push_back(1'b0);
                if (!in_clint(fetch_req.addr)) ax_addr_q.push_back(fetch_req.addr);
            end
            if (lsu_req.valid && lsu_ready) begin
                grant_log.push_back(1'b1);
                if (!in_clint(lsu_req.addr)) ax_addr_q.push_back(lsu_req.addr);
                if (!in_clint(lsu_req.addr) && lsu_req.write) begin
                    w_exp_q.push_back('{valid: 1'b1, data: lsu_req.wdata,
                                        strb: lsu_req.wstrb, last: 1'b1});
                end
            end
            if (io_master_ar.valid && io_master_arready) begin
                check_ax_issue("io_master_ar", io_master_ar);
                io_master_arready <= 1'b0;
                rd_idx            <= io_master_ar.addr[9:2];
                r_pend            <= 1'b1;
                r_wait            <= next_delay();
                ar_wait           <= next_delay();
            end else if (io_master_ar.valid) begin
                if (ar_wait == 0) io_master_arready <= 1'b1;
                else ar_wait <= ar_wait - 1'b1;
            end
            if (io_master_r.valid) begin
                if (io_master_rready) io_master_r <= '0;
            end else if (r_pend) begin
                if (r_wait == 0) begin
                    io_master_r <= '{valid: 1'b1, data: mem[rd_idx], resp: axi_resp_okay,
                                     last: 1'b1, id: '0};
                    r_pend      <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1'b1;
                end
            end
            if (io_master_aw.valid && io_master_awready) begin
                check_ax_issue("io_master_aw", io_master_aw);
                io_master_awready <= 1'b0;
                wr_idx            <= io_master_aw.addr[9:2];
                aw_got            <= 1'b1;
                aw_wait           <= next_delay();
            end else if (io_master_aw.valid) begin
                if (aw_wait == 0) io_master_awready <= 1'b1;
                else aw_wait <= aw_wait - 1'b1;
            end
            if (io_master_w.valid && io_master_wready) begin
                check_w_issue(io_master_w);
                io_master_wready <= 1'b0;
                w_data           <= io_master_w.data;
                w_strb           <= io_master_w.strb;
                w_got            <= 1'b1;
                w_wait           <= next_delay();
            end else if (io_master_w.valid) begin
                if (w_wait == 0) io_master_wready <= 1'b1;
                else w_wait <= w_wait - 1'b1;
            end
            if (aw_got && w_got) begin            // Commit with byte lanes
                for (bi = 0; bi < strb_w; bi++) begin
                    if (w_strb[bi]) mem[wr_idx][8*bi +: 8] <= w_data[8*bi +: 8];
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_wait <= next_delay();
            end
            if (io_master_b.valid) begin
                if (io_master_bready) io_master_b <= '0;
            end else if (b_pend) begin
                if (b_wait == 0) begin
                    io_master_b <= '{valid: 1'b1, resp: axi_resp_okay, id: '0};
                    b_pend      <= 1'b0;
                end else begin
                    b_wait <= b_wait - 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h8313_0d29));
        for (int i = 0; i < 64; i++) delay_tab[i] = $urandom % 4;
        for (int i = 0; i < 256; i++) mem[i] = ext_base | (i << 2);   // Word holds its address
        vec_tab[0]  = '{1'b0, 1'b0, 32'h8000_0010, 32'h0, 4'h0, 32'h8000_0010, axi_resp_okay};
        vec_tab[1]  = '{1'b1, 1'b0, 32'h8000_0104, 32'h0, 4'h0, 32'h8000_0104, axi_resp_okay};
        vec_tab[2]  = '{1'b0, 1'b0, 32'h8000_03FC, 32'h0, 4'h0, 32'h8000_03FC, axi_resp_okay};
        vec_tab[3]  = '{1'b1, 1'b1, 32'h8000_0020, 32'hDEAD_BEEF, 4'b0101, 32'h0, axi_resp_okay};
        vec_tab[4]  = '{1'b1, 1'b0, 32'h8000_0020, 32'h0, 4'h0, 32'h80AD_00EF, axi_resp_okay};
        vec_tab[5]  = '{1'b1, 1'b1, 32'h8000_0024, 32'hCAFE_F00D, 4'b1110, 32'h0, axi_resp_okay};
        vec_tab[6]  = '{1'b0, 1'b0, 32'h8000_0024, 32'h0, 4'h0, 32'hCAFE_F024, axi_resp_okay};
        vec_tab[7]  = '{1'b1, 1'b0, 32'h0200_0008, 32'h0, 4'h0, 32'h0, axi_resp_slverr};
        vec_tab[8]  = '{1'b0, 1'b0, 32'h0200_4000, 32'h0, 4'h0, 32'hFFFF_FFFF, axi_resp_okay};
        vec_tab[9]  = '{1'b1, 1'b1, 32'h0200_4004, 32'h1234_5678, 4'hF, 32'h0, axi_resp_okay};
        vec_tab[10] = '{1'b1, 1'b0, 32'h0200_4004, 32'h0, 4'h0, 32'h1234_5678, axi_resp_okay};
        vec_tab[11] = '{1'b1, 1'b1, 32'h0200_4004, 32'hFFFF_FFFF, 4'hF, 32'h0, axi_resp_okay};
        vec_tab[12] = '{1'b1, 1'b1, 32'h0200_FFF0, 32'h5555_AAAA, 4'hF, 32'h0, axi_resp_slverr};
        arst_n            = 1'b0;
        fetch_req         = '0;
        lsu_req           = '0;
        io_master_arready = 1'b0;
        io_master_awready = 1'b0;
        io_master_wready  = 1'b0;
        io_master_r       = '0;
        io_master_b       = '0;
        {ar_wait, aw_wait, w_wait, r_wait, b_wait} = '0;
        {r_pend, b_pend, aw_got, w_got}            = '0;
        repeat (10) @(posedge clock);
        if (io_master_ar.valid || io_master_aw.valid || io_master_w.valid ||
            io_master_rready || io_master_bready || fetch_ready || lsu_ready ||
            fetch_rsp.valid || lsu_rsp.valid) begin
            fail_now("A valid or ready output is high during reset");
        end
        check_irq(1'b0, 1'b0);
        arst_n <= 1'b1;
        for (int k = 0; k < num_vec; k++) begin
            do_access(vec_tab[k].use_lsu, vec_tab[k].write, vec_tab[k].addr,
                      vec_tab[k].data, vec_tab[k].strb, rsp, lat);
            check_rsp(vec_tab[k].use_lsu ? "lsu_rsp" : "fetch_rsp", rsp,
                      '{valid: 1'b1, rdata: vec_tab[k].exp_data, resp: vec_tab[k].exp_resp});
            if (in_clint(vec_tab[k].addr) && lat != 3) begin
                fail_now($sformatf("Error t=%0t clint latency: got %0d expected 3", $time, lat));
            end
        end
        // Software interrupt on and off
        do_access(1'b1, 1'b1, clint_base | clint_msip_off, 32'h1, 4'hF, rsp, lat);
        check_irq(1'b0, 1'b1);
        do_access(1'b1, 1'b1, clint_base | clint_msip_off, 32'h0, 4'hF, rsp, lat);
        check_irq(1'b0, 1'b0);
        // Timer compare just ahead of mtime
        do_access(1'b1, 1'b0, clint_base | clint_mtime_hi_off, '0, '0, rsp, lat);
        check_rsp("lsu_rsp", rsp, '{valid: 1'b1, rdata: 32'h0, resp: axi_resp_okay});
        do_access(1'b1, 1'b0, clint_base | clint_mtime_off, '0, '0, rsp, lat);
        t_now = rsp.rdata;
        if (rsp.resp !== axi_resp_okay || t_now == 0 || t_now > 32'd100_000) begin
            fail_now("mtime read returned an implausible value");
        end
        do_access(1'b1, 1'b1, clint_base | clint_mtimecmp_off, t_now + 32'd64, 4'hF, rsp, lat);
        do_access(1'b1, 1'b1, clint_base | clint_mtimecmp_hi_off, 32'h0, 4'hF, rsp, lat);
        check_irq(1'b0, 1'b0);                           // Compare still ahead
        wait_timer(1'b1);
        check_irq(1'b1, 1'b0);
        do_access(1'b1, 1'b1, clint_base | clint_mtimecmp_hi_off, 32'hFFFF_FFFF, 4'hF, rsp, lat);
        do_access(1'b1, 1'b1, clint_base | clint_mtimecmp_off, 32'hFFFF_FFFF, 4'hF, rsp, lat);
        wait_timer(1'b0);
        check_irq(1'b0, 1'b0);
        // Both ports at once, grants must alternate
        grant_log.delete();
        fork
            run_port(1'b0, 32'h8000_0040, 32'h8000_0044);
            run_port(1'b1, 32'h8000_0080, 32'h8000_0084);
        join
        if (grant_log.size() != 4) begin
            fail_now($sformatf("Expected 4 grants under contention, saw %0d", grant_log.size()));
        end
        for (int k = 1; k < 4; k++) begin
            if (grant_log[k] == grant_log[k-1]) begin
                fail_now("One port was granted twice in a row while the other waited");
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/fabric_pkg.sv
design/bus_arbiter.sv
design/clint_timer.sv
design/bus_router.sv
design/cpu_fabric_top.sv
sim/tb_cpu_fabric.sv

/* Bender.yml */
package:
  name: cpu_fabric

sources:
  - files:
      - design/fabric_pkg.sv
      - design/bus_arbiter.sv
      - design/clint_timer.sv
      - design/bus_router.sv
      - design/cpu_fabric_top.sv
  - target: simulation
    files:
      - sim/tb_cpu_fabric.sv
